// File: lc3b_pipe.f
+incdir+logic
logic/lc3b_isa_pkg.sv
logic/lc3b_pipe_pkg.sv
logic/lc3b_regfile.sv
logic/lc3b_decode.sv
logic/lc3b_execute.sv
logic/lc3b_writeback.sv
logic/lc3b_core.sv
tests/lc3b_core_checker.sv
tests/lc3b_core_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module lc3b_core_tb \
    -f lc3b_pipe.f \
    -o sim_lc3b_core

./obj_dir/sim_lc3b_core

// File: tests/lc3b_core_tb.sv
`include "lc3b_macros.svh"

module lc3b_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTR = 2000;
    localparam int SEED = 61259;
    localparam int TIMEOUT_NS = 2 * NUM_INSTR * CLK_PERIOD_NS + RESET_CYCLES * CLK_PERIOD_NS;

    typedef struct packed
    {
        int                    due;     // falling edge count when wb shows it
        lc3b_pipe_pkg::wb_t    rec;
    } wb_entry_t;

    typedef struct packed
    {
        int                    due;
        lc3b_isa_pkg::nzp_t    flags;
    } cc_entry_t;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      instr_valid;
    lc3b_isa_pkg::word_t       instr;
    lc3b_pipe_pkg::wb_t        wb;
    lc3b_isa_pkg::nzp_t        cc;

    lc3b_isa_pkg::word_t       model_regs [`LC3B_NUM_REGS];
    lc3b_isa_pkg::nzp_t        expected_cc;
    lc3b_isa_pkg::reg_idx_t    recent [3];      // last written dests, for dependencies
    wb_entry_t                 wb_q [$];
    cc_entry_t                 cc_q [$];
    int                        cycle;
    int                        issued;

    lc3b_core uut
    (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .wb(wb),
        .cc(cc)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_wb(input lc3b_pipe_pkg::wb_t expected, input lc3b_pipe_pkg::wb_t actual);
        if (actual !== expected)
        begin
            $display("** Error at %t: wb expected v=%0b r%0d %h, actual v=%0b r%0d %h",
                     $time, expected.valid, expected.dest, expected.data,
                     actual.valid, actual.dest, actual.data);
            abort_run("wb mismatch");
        end
    endtask

    task automatic check_cc(input lc3b_isa_pkg::nzp_t expected, input lc3b_isa_pkg::nzp_t actual);
        if (actual !== expected)
        begin
            $display("** Error at %t: cc expected nzp=%b, actual nzp=%b",
                     $time, expected, actual);
            abort_run("cc mismatch");
        end
    endtask

    // n, z, p from the sign and zero test of the written value
    function automatic lc3b_isa_pkg::nzp_t flags_of(input lc3b_isa_pkg::word_t value);
        lc3b_isa_pkg::nzp_t flags;
        flags.n = value[15];
        flags.z = (value == 16'h0000);
        flags.p = !value[15] && (value != 16'h0000);
        return flags;
    endfunction

    task automatic pick_source(output lc3b_isa_pkg::reg_idx_t idx);
        logic [1:0] slot;
        slot = 2'($urandom_range(2));
        if ($urandom_range(99) < 50)
            idx = recent[slot];                         // distance one to three
        else
            idx = lc3b_isa_pkg::reg_idx_t'($urandom_range(7));
    endtask

    // builds one word and runs it through the model in program order
    task automatic make_instr(output lc3b_isa_pkg::word_t word);
        logic [3:0]                op;
        lc3b_isa_pkg::reg_idx_t    dest;
        lc3b_isa_pkg::reg_idx_t    src1;
        lc3b_isa_pkg::reg_idx_t    src2;
        logic [4:0]                imm5;
        logic                      use_imm;
        lc3b_isa_pkg::word_t       a;
        lc3b_isa_pkg::word_t       b;
        lc3b_isa_pkg::word_t       result;
        int                        kind;
        wb_entry_t                 wb_entry;
        cc_entry_t                 cc_entry;
        if ($urandom_range(99) < 5)
        begin
            do
                op = 4'($urandom());
            while (op == 4'b0001 || op == 4'b0101 || op == 4'b1001);
            word = {op, 12'($urandom())};               // dropped at decode
        end
        else
        begin
            kind = $urandom_range(2);
            use_imm = 1'($urandom_range(1));
            dest = lc3b_isa_pkg::reg_idx_t'($urandom_range(7));
            pick_source(src1);
            pick_source(src2);
            imm5 = 5'($urandom());
            a = model_regs[src1];
            b = use_imm ? {{11{imm5[4]}}, imm5} : model_regs[src2];
            case (kind)
                0:
                begin
                    op = lc3b_isa_pkg::op_add;
                    result = a + b;
                end
                1:
                begin
                    op = lc3b_isa_pkg::op_and;
                    result = a & b;
                end
                default:
                begin
                    op = lc3b_isa_pkg::op_not;
                    result = ~a;
                end
            endcase
            if (kind == 2)
                word = {op, dest, src1, 6'b111111};
            else if (use_imm)
                word = {op, dest, src1, 1'b1, imm5};
            else
                word = {op, dest, src1, 3'b000, src2};
            model_regs[dest] = result;
            wb_entry.due = cycle + 2;                   // decode then execute register
            wb_entry.rec.valid = 1'b1;
            wb_entry.rec.dest = dest;
            wb_entry.rec.data = result;
            wb_q.push_back(wb_entry);
            cc_entry.due = cycle + 3;                   // one edge after wb
            cc_entry.flags = flags_of(result);
            cc_q.push_back(cc_entry);
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = dest;
        end
    endtask

    task automatic check_outputs();
        wb_entry_t wb_head;
        cc_entry_t cc_head;
        if (wb_q.size() > 0 && wb_q[0].due == cycle)
        begin
            wb_head = wb_q.pop_front();
            check_wb(wb_head.rec, wb);
        end
        else if (wb.valid !== 1'b0)
        begin
            abort_run("unexpected writeback: wb.valid high with no result due");
        end
        if (cc_q.size() > 0 && cc_q[0].due == cycle)
        begin
            cc_head = cc_q.pop_front();
            expected_cc = cc_head.flags;
        end
        check_cc(expected_cc, cc);
    endtask

    // called at a falling edge, checks then drives for the next rising edge
    task automatic run_cycle(input bit may_issue);
        lc3b_isa_pkg::word_t    word;
        bit                     issue;
        check_outputs();
        issue = may_issue && ($urandom_range(99) < 80);
        if (issue)
        begin
            make_instr(word);
            issued++;
        end
        else
        begin
            word = 16'($urandom());     // junk while the strobe is low
        end
        instr_valid = issue;
        instr = word;
        @(negedge clk);
        cycle++;
    endtask

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(SEED));
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        model_regs = '{default: '0};
        recent = '{default: '0};
        expected_cc = '{n: 1'b0, z: 1'b1, p: 1'b0};
        cycle = 0;
        issued = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (8) run_cycle(1'b0);     // quiet core after reset
        while (issued < NUM_INSTR)
            run_cycle(1'b1);
        while (wb_q.size() > 0 || cc_q.size() > 0)
            run_cycle(1'b0);
        repeat (4) run_cycle(1'b0);

        $display("Test passed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        abort_run("timeout: the run did not complete in time");
    end

endmodule : lc3b_core_tb

// File: tests/lc3b_core_checker.sv
module lc3b_core_checker
(
    input  logic                  clk,
    input  logic                  rst,
    input  lc3b_pipe_pkg::wb_t    wb,
    input  lc3b_isa_pkg::nzp_t    cc
);

    timeunit 1ns;
    timeprecision 1ps;

    // execute register comes out of reset empty
    wb_idle_after_reset: assert property (@(posedge clk) rst |=> !wb.valid)
        else $error("wb.valid high in the cycle after reset");

    cc_one_hot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot({cc.n, cc.z, cc.p})
    )
        else $error("cc is not one-hot: n=%0b z=%0b p=%0b", cc.n, cc.z, cc.p);

    // cc loads at the edge where a valid record leaves execute
    cc_follows_wb: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(cc) |-> $past(wb.valid)
    )
        else $error("cc changed without a writeback in the cycle before");

endmodule : lc3b_core_checker

bind lc3b_core lc3b_core_checker core_checks
(
    .clk(clk),
    .rst(rst),
    .wb(wb),
    .cc(cc)
);

// File: logic/lc3b_core.sv
module lc3b_core
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  lc3b_isa_pkg::word_t     instr,
    output lc3b_pipe_pkg::wb_t      wb,
    output lc3b_isa_pkg::nzp_t      cc
);

    lc3b_isa_pkg::reg_idx_t   rd_idx_a;
    lc3b_isa_pkg::reg_idx_t   rd_idx_b;
    lc3b_isa_pkg::word_t      rd_data_a;
    lc3b_isa_pkg::word_t      rd_data_b;
    logic                     wr_en;
    lc3b_isa_pkg::reg_idx_t   wr_idx;
    lc3b_isa_pkg::word_t      wr_data;
    lc3b_pipe_pkg::dec_t      dec;
    lc3b_pipe_pkg::wb_t       ex;
    lc3b_pipe_pkg::wb_t       retired;

    lc3b_regfile regfile
    (
        .clk(clk),
        .rst(rst),
        .rd_idx_a(rd_idx_a),
        .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data)
    );

    lc3b_decode decode
    (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .rd_idx_a(rd_idx_a),
        .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .dec(dec)
    );

    lc3b_execute execute
    (
        .clk(clk),
        .rst(rst),
        .dec(dec),
        .retired(retired),
        .ex(ex)
    );

    lc3b_writeback writeback
    (
        .clk(clk),
        .rst(rst),
        .ex(ex),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data),
        .retired(retired),
        .cc(cc)
    );

    assign wb = ex;     // execute register is the result port

endmodule : lc3b_core

// File: logic/lc3b_writeback.sv
module lc3b_writeback
(
    input  logic                     clk,
    input  logic                     rst,
    input  lc3b_pipe_pkg::wb_t       ex,
    output logic                     wr_en,
    output lc3b_isa_pkg::reg_idx_t   wr_idx,
    output lc3b_isa_pkg::word_t      wr_data,
    output lc3b_pipe_pkg::wb_t       retired,
    output lc3b_isa_pkg::nzp_t       cc
);

    lc3b_isa_pkg::nzp_t   gen_cc;

    // regfile takes the write at the next edge
    assign wr_en = ex.valid;
    assign wr_idx = ex.dest;
    assign wr_data = ex.data;

    always_comb
    begin
        gen_cc.n = ex.data[$bits(ex.data)-1];     // sign bit
        gen_cc.z = (ex.data == '0);
        gen_cc.p = !gen_cc.n && !gen_cc.z;
    end

    // keeps the write for one cycle so execute can still see it
    always_ff @(posedge clk)
    begin
        retired <= ex;
        if (rst)
            retired.valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cc <= '{n: 1'b0, z: 1'b1, p: 1'b0};   // registers are all zero
        end
        else if (ex.valid)
        begin
            cc <= gen_cc;
        end
    end

endmodule : lc3b_writeback

// File: logic/lc3b_execute.sv
module lc3b_execute
(
    input  logic                   clk,
    input  logic                   rst,
    input  lc3b_pipe_pkg::dec_t    dec,
    input  lc3b_pipe_pkg::wb_t     retired,
    output lc3b_pipe_pkg::wb_t     ex
);

    lc3b_isa_pkg::word_t   opnd_a;      // src1 after forwarding
    lc3b_isa_pkg::word_t   src2_val;    // src2 after forwarding
    lc3b_isa_pkg::word_t   opnd_b;      // src2 or immediate
    lc3b_isa_pkg::word_t   result;
    lc3b_pipe_pkg::wb_t    ex_nxt;

    // youngest pending write wins, regfile read is the fallback
    function automatic lc3b_isa_pkg::word_t forward
    (
        input lc3b_isa_pkg::reg_idx_t   src,
        input lc3b_isa_pkg::word_t      read_val,
        input lc3b_pipe_pkg::wb_t       ex_rec,
        input lc3b_pipe_pkg::wb_t       ret_rec
    );
        lc3b_isa_pkg::word_t val;
        val = read_val;
        if (ex_rec.valid && (ex_rec.dest == src))
            val = ex_rec.data;          // one instruction ahead
        else if (ret_rec.valid && (ret_rec.dest == src))
            val = ret_rec.data;         // two ahead, written at last edge
        return val;
    endfunction

    always_comb
    begin
        opnd_a = forward(dec.src1, dec.op_a, ex, retired);
        src2_val = forward(dec.src2, dec.op_b, ex, retired);
        opnd_b = dec.use_imm ? dec.imm : src2_val;
    end

    always_comb
    begin
        case (dec.alu_op)
            lc3b_isa_pkg::alu_add:
            begin
                result = opnd_a + opnd_b;
            end
            lc3b_isa_pkg::alu_and:
            begin
                result = opnd_a & opnd_b;
            end
            lc3b_isa_pkg::alu_not:
            begin
                result = ~opnd_a;
            end
            default:
            begin
                result = opnd_a;        // unused encoding
            end
        endcase
    end

    always_comb
    begin
        ex_nxt.valid = dec.valid;
        ex_nxt.dest = dec.dest;
        ex_nxt.data = result;
    end

    always_ff @(posedge clk)
    begin
        ex <= ex_nxt;
        if (rst)
            ex.valid <= 1'b0;
    end

endmodule : lc3b_execute

// File: logic/lc3b_decode.sv
module lc3b_decode
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  lc3b_isa_pkg::word_t      instr,
    output lc3b_isa_pkg::reg_idx_t   rd_idx_a,
    output lc3b_isa_pkg::reg_idx_t   rd_idx_b,
    input  lc3b_isa_pkg::word_t      rd_data_a,
    input  lc3b_isa_pkg::word_t      rd_data_b,
    output lc3b_pipe_pkg::dec_t      dec
);

    lc3b_isa_pkg::opcode_t   opcode;
    lc3b_isa_pkg::alu_op_t   alu_op;
    logic                    kept;          // opcode handled by this core
    lc3b_pipe_pkg::dec_t     dec_nxt;

    always_comb
    begin
        opcode = lc3b_isa_pkg::opcode_t'(instr[15:12]);
        kept = 1'b1;
        alu_op = lc3b_isa_pkg::alu_add;

        case (opcode)
            lc3b_isa_pkg::op_add:
            begin
                alu_op = lc3b_isa_pkg::alu_add;
            end
            lc3b_isa_pkg::op_and:
            begin
                alu_op = lc3b_isa_pkg::alu_and;
            end
            lc3b_isa_pkg::op_not:
            begin
                alu_op = lc3b_isa_pkg::alu_not;
            end
            default:
            begin
                kept = 1'b0;        // dropped, never reaches writeback
            end
        endcase
    end

    // sr1 in [8:6], sr2 in [2:0], both read every cycle
    assign rd_idx_a = instr[8:6];
    assign rd_idx_b = instr[2:0];

    always_comb
    begin
        dec_nxt.valid = instr_valid && kept;
        dec_nxt.alu_op = alu_op;
        dec_nxt.dest = instr[11:9];
        dec_nxt.src1 = rd_idx_a;
        dec_nxt.src2 = rd_idx_b;
        // not has bit 5 set as part of its encoding, it takes no immediate
        dec_nxt.use_imm = instr[5] && (opcode != lc3b_isa_pkg::op_not);
        dec_nxt.imm = lc3b_isa_pkg::word_t'($signed(instr[4:0]));   // sext imm5
        dec_nxt.op_a = rd_data_a;
        dec_nxt.op_b = rd_data_b;
    end

    always_ff @(posedge clk)
    begin
        dec <= dec_nxt;
        if (rst)
            dec.valid <= 1'b0;
    end

endmodule : lc3b_decode

// File: logic/lc3b_regfile.sv
`include "lc3b_macros.svh"

module lc3b_regfile
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`LC3B_REG_W-1:0]   rd_idx_a,
    input  logic [`LC3B_REG_W-1:0]   rd_idx_b,
    output logic [`LC3B_WORD_W-1:0]  rd_data_a,
    output logic [`LC3B_WORD_W-1:0]  rd_data_b,
    input  logic                     wr_en,
    input  logic [`LC3B_REG_W-1:0]   wr_idx,
    input  logic [`LC3B_WORD_W-1:0]  wr_data
);

    logic [`LC3B_WORD_W-1:0] regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // no write-through, a same-cycle write is picked up by forwarding
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule : lc3b_regfile

// File: logic/lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

    // decode register contents, handed from decode to execute
    typedef struct packed
    {
        logic                     valid;
        lc3b_isa_pkg::alu_op_t    alu_op;
        lc3b_isa_pkg::reg_idx_t   dest;
        lc3b_isa_pkg::reg_idx_t   src1;
        lc3b_isa_pkg::reg_idx_t   src2;
        logic                     use_imm;
        lc3b_isa_pkg::word_t      imm;      // sign extended imm5
        lc3b_isa_pkg::word_t      op_a;     // regfile value of src1
        lc3b_isa_pkg::word_t      op_b;     // regfile value of src2
    } dec_t;

    // a register write, both in flight and just retired
    typedef struct packed
    {
        logic                     valid;
        lc3b_isa_pkg::reg_idx_t   dest;
        lc3b_isa_pkg::word_t      data;
    } wb_t;

endpackage : lc3b_pipe_pkg

// File: logic/lc3b_isa_pkg.sv
`include "lc3b_macros.svh"

package lc3b_isa_pkg;

    typedef logic [`LC3B_WORD_W-1:0] word_t;    // data or instruction word
    typedef logic [`LC3B_REG_W-1:0] reg_idx_t;

    // full lc3b opcode map, only add/and/not are executed here
    typedef enum logic [3:0]
    {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } opcode_t;

    typedef enum logic [1:0]
    {
        alu_add = 2'b00,
        alu_and = 2'b01,
        alu_not = 2'b10     // bitwise invert of operand a
    } alu_op_t;

    typedef struct packed
    {
        logic n;
        logic z;
        logic p;
    } nzp_t;                // one-hot condition codes

endpackage : lc3b_isa_pkg

// File: logic/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// data path and instruction word width
`define LC3B_WORD_W 16

`define LC3B_NUM_REGS 8     // architectural registers r0..r7

`define LC3B_REG_W 3        // register index width

`endif
